// File: Bender.yml
package:
  name: rename_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/rename_pkg.sv
      - logic/rob_if.sv
      - logic/regstat.sv
      - logic/issue_unit.sv
      - logic/reorder_buffer.sv
      - logic/commit_unit.sv
      - logic/rename_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/clock_gen.sv
      - testbench/rename_props.sv
      - testbench/rename_tb.sv

// File: include/rename_cfg.svh
// sizing macros for the rename and retire slice
// include wherever the rob depth, tag width or register count is needed
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

`define ROB_DEPTH 16 // reorder buffer entries
`define TAG_W     4  // rob tag width, log2 of ROB_DEPTH
`define NUM_REGS  32 // architectural registers, x0 included

`endif

// File: logic/commit_unit.sv
// in-order retirement, one rob head at a time
// pops the head and clears its status entry, then offers it outside on
// a four-phase commit_req/commit_ack handshake
`timescale 1ns/10ps
`include "rename_cfg.svh"

module commit_unit (
    input  logic              clk,
    input  logic              reset,
    rob_retire_if.commit      retire,
    output logic              commit_req,
    input  logic              commit_ack,
    output logic [`TAG_W-1:0] commit_tag,
    output logic [4:0]        commit_dest,
    output logic              commit_writes,
    output logic              clr_en,
    output logic [4:0]        clr_dest,
    output logic [`TAG_W-1:0] clr_tag
);

    typedef enum logic [1:0] {cm_idle, cm_req, cm_drain} state_t;

    state_t state;
    logic   take;

    assign take = (state == cm_idle) && retire.head_valid;

    // pop and clear land on the edge commit_req rises
    assign retire.retire_pop = take;
    assign clr_en   = take && retire.head_writes;
    assign clr_dest = retire.head_dest;
    assign clr_tag  = retire.head_tag; // regstat drops it if a newer writer owns the reg

    assign commit_req = (state == cm_req);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cm_idle;
        end else begin
            case (state)
                cm_idle:  if (retire.head_valid) state <= cm_req;
                cm_req:   if (commit_ack) state <= cm_drain;
                cm_drain: if (!commit_ack) state <= cm_idle; // wait for ack low
                default:  state <= cm_idle;
            endcase
        end
    end

    // retired head, stable while commit_req is high
    always_ff @(posedge clk) begin
        if (take) begin
            commit_tag    <= retire.head_tag;
            commit_dest   <= retire.head_dest;
            commit_writes <= retire.head_writes;
        end
    end

endmodule

// File: logic/issue_unit.sv
// issue side: decodes an incoming word, gets a rob tag and renames it
// instr_req/instr_ack is a four-phase handshake, outputs held while ack is high
// operand status is sampled in the cycle the rob grants the tag
`timescale 1ns/10ps
`include "rename_cfg.svh"

module issue_unit import rename_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              instr_req,
    input  instr_word_u       instr_word,
    output logic              instr_ack,
    output logic [`TAG_W-1:0] q_j,
    output logic [`TAG_W-1:0] q_k,
    output logic [`TAG_W-1:0] rob_tag,
    output logic              rs1_busy,
    output logic              rs2_busy,
    output logic              uses_rs2,
    output logic [11:0]       imm,
    rob_alloc_if.issue        alloc,
    output logic [4:0]        rd_addr_a,
    output logic [4:0]        rd_addr_b,
    input  reg_stat_t         stat_a,
    input  reg_stat_t         stat_b,
    output logic              wr_en,
    output logic [4:0]        wr_dest,
    output logic [`TAG_W-1:0] wr_tag
);

    typedef enum logic [1:0] {st_idle, st_alloc, st_respond, st_release} state_t;

    state_t state;
    logic   is_op;
    logic   is_op_imm;
    logic   dec_writes;
    logic   take; // tag granted this cycle

    assign is_op     = (instr_word.r_fmt.opcode == OPC_OP);
    assign is_op_imm = (instr_word.i_fmt.opcode == OPC_OP_IMM);
    assign dec_writes = (is_op || is_op_imm) && (instr_word.r_fmt.rd != 5'd0); // x0 never renamed

    // unused sources point at x0 so they come back as tag 0, not busy
    assign rd_addr_a = (is_op || is_op_imm) ? instr_word.r_fmt.rs1 : 5'd0;
    assign rd_addr_b = is_op ? instr_word.r_fmt.rs2 : 5'd0;

    assign alloc.alloc_req    = (state == st_alloc);
    assign alloc.alloc_dest   = dec_writes ? instr_word.r_fmt.rd : 5'd0;
    assign alloc.alloc_writes = dec_writes;

    assign take = (state == st_alloc) && alloc.alloc_ack;

    // own dest is written at the edge ack rises, sources were read before it
    assign wr_en   = take && dec_writes;
    assign wr_dest = instr_word.r_fmt.rd;
    assign wr_tag  = alloc.alloc_tag;

    assign instr_ack = (state == st_respond);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:    if (instr_req) state <= st_alloc;
                st_alloc:   if (alloc.alloc_ack) state <= st_respond; // rob full stalls here
                st_respond: if (!instr_req) state <= st_release;
                st_release: if (!alloc.alloc_ack) state <= st_idle; // let rob finish its phase
                default:    state <= st_idle;
            endcase
        end
    end

    // renamed operands, held for the outside while instr_ack is high
    always_ff @(posedge clk) begin
        if (take) begin
            q_j      <= stat_a.rob_tag;
            rs1_busy <= stat_a.busy;
            q_k      <= stat_b.rob_tag;
            rs2_busy <= stat_b.busy;
            rob_tag  <= alloc.alloc_tag;
            imm      <= is_op_imm ? instr_word.i_fmt.imm : 12'd0;
            uses_rs2 <= is_op;
        end
    end

endmodule

// File: logic/regstat.sv
// register status table, one entry per architectural register but x0
// issue writes the newest writer tag, commit clears it only on a tag match
// reads are combinational and see a clear landing in the same cycle
`timescale 1ns/10ps
`include "rename_cfg.svh"

module regstat import rename_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [4:0]        rd_addr_a,
    input  logic [4:0]        rd_addr_b,
    input  logic              wr_en,
    input  logic [4:0]        wr_dest,
    input  logic [`TAG_W-1:0] wr_tag,
    input  logic              clr_en,
    input  logic [4:0]        clr_dest,
    input  logic [`TAG_W-1:0] clr_tag,
    output reg_stat_t         stat_a,
    output reg_stat_t         stat_b
);

    reg_stat_t table_q [1:`NUM_REGS-1]; // x0 has no storage
    reg_stat_t clr_entry;
    logic      clr_hit;

    // x0 always reads as idle
    function automatic reg_stat_t lookup(input logic [4:0] addr);
        reg_stat_t ent;
        ent = '0;
        if (addr != 5'd0) begin
            ent = table_q[addr];
        end
        return ent;
    endfunction

    // read with the pending clear folded in
    function automatic reg_stat_t read_port(input logic [4:0] addr);
        reg_stat_t ent;
        ent = lookup(addr);
        if (clr_hit && (addr == clr_dest)) begin
            ent = '0; // retiring tag must not be handed out again
        end
        return ent;
    endfunction

    assign clr_entry = lookup(clr_dest);

    // an older writer retiring must not free a register a newer one claimed
    assign clr_hit = clr_en && clr_entry.busy && (clr_entry.rob_tag == clr_tag);

    assign stat_a = read_port(rd_addr_a);
    assign stat_b = read_port(rd_addr_b);

    always_ff @(posedge clk) begin
        for (int i = 1; i < `NUM_REGS; i++) begin
            if (reset) begin
                table_q[i] <= '0; // doubles as flush
            end else if (wr_en && (wr_dest == 5'(i))) begin
                table_q[i].busy    <= 1'b1; // write wins over a clear
                table_q[i].rob_tag <= wr_tag;
            end else if (clr_hit && (clr_dest == 5'(i))) begin
                table_q[i] <= '0;
            end
        end
    end

endmodule

// File: logic/rename_core.sv
// top of the rename and retire slice
// instruction handshake in, completion pulses in, commit handshake out
`timescale 1ns/10ps
`include "rename_cfg.svh"

module rename_core import rename_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              instr_req,
    input  logic [31:0]       instr_word,
    output logic              instr_ack,
    output logic [`TAG_W-1:0] q_j,
    output logic [`TAG_W-1:0] q_k,
    output logic              rs1_busy,
    output logic              rs2_busy,
    output logic [`TAG_W-1:0] rob_tag,
    output logic [11:0]       imm,
    output logic              uses_rs2,
    input  logic              complete_valid,
    input  logic [`TAG_W-1:0] complete_tag,
    output logic              commit_req,
    input  logic              commit_ack,
    output logic [`TAG_W-1:0] commit_tag,
    output logic [4:0]        commit_dest,
    output logic              commit_writes
);

    rob_alloc_if  alloc_bus ();
    rob_retire_if retire_bus ();

    logic [4:0]        rd_addr_a;
    logic [4:0]        rd_addr_b;
    reg_stat_t         stat_a;
    reg_stat_t         stat_b;
    logic              wr_en;
    logic [4:0]        wr_dest;
    logic [`TAG_W-1:0] wr_tag;
    logic              clr_en;
    logic [4:0]        clr_dest;
    logic [`TAG_W-1:0] clr_tag;

    issue_unit u_issue (
        .clk, .reset, .instr_req, .instr_word, .instr_ack,
        .q_j, .q_k, .rob_tag, .rs1_busy, .rs2_busy, .uses_rs2, .imm,
        .alloc(alloc_bus.issue),
        .rd_addr_a, .rd_addr_b, .stat_a, .stat_b,
        .wr_en, .wr_dest, .wr_tag
    );

    regstat u_regstat (
        .clk, .reset, .rd_addr_a, .rd_addr_b,
        .wr_en, .wr_dest, .wr_tag,
        .clr_en, .clr_dest, .clr_tag,
        .stat_a, .stat_b
    );

    reorder_buffer u_rob (
        .clk, .reset, .complete_valid, .complete_tag,
        .alloc(alloc_bus.rob),
        .retire(retire_bus.rob)
    );

    commit_unit u_commit (
        .clk, .reset,
        .retire(retire_bus.commit),
        .commit_req, .commit_ack, .commit_tag, .commit_dest, .commit_writes,
        .clr_en, .clr_dest, .clr_tag
    );

endmodule

// File: logic/rename_pkg.sv
// shared types for the rename slice
// instruction word views, register status entry and rob entry
`include "rename_cfg.svh"

package rename_pkg;

    // R-type layout, used by OP
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // I-type layout, used by OP-IMM
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // same 32 bits seen either way, opcode picks the view
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_word_u;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    typedef struct packed {
        logic              busy;    // a rob entry will write this register
        logic [`TAG_W-1:0] rob_tag; // newest writer
    } reg_stat_t;

    typedef struct packed {
        logic [4:0] dest;
        logic       writes; // 0 for non-writing instructions
        logic       done;   // set by completion
    } rob_entry_t;

endpackage

// File: logic/reorder_buffer.sv
// circular reorder buffer, tags handed out in program order
// allocation answers a four-phase request, completion marks entries done
// the head is offered to the commit unit once it is done
`timescale 1ns/10ps
`include "rename_cfg.svh"

module reorder_buffer import rename_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              complete_valid,
    input  logic [`TAG_W-1:0] complete_tag,
    rob_alloc_if.rob          alloc,
    rob_retire_if.rob         retire
);

    rob_entry_t        entries [`ROB_DEPTH];
    logic [`TAG_W-1:0] head;
    logic [`TAG_W-1:0] tail;
    logic [`TAG_W:0]   count;    // 0..ROB_DEPTH
    logic              alloc_fire;
    logic [`TAG_W-1:0] cpl_offset;
    logic              cpl_in_flight;

    // new request, not yet answered, and room left
    assign alloc_fire = alloc.alloc_req && !alloc.alloc_ack && (count < `ROB_DEPTH);

    // distance from head decides whether the tag is live
    assign cpl_offset    = complete_tag - head; // wraps mod depth
    assign cpl_in_flight = complete_valid && ({1'b0, cpl_offset} < count);

    always_ff @(posedge clk) begin
        if (reset) begin
            head            <= '0;
            tail            <= '0;
            count           <= '0;
            alloc.alloc_ack <= 1'b0;
        end else begin
            if (alloc_fire) begin
                alloc.alloc_ack <= 1'b1;
                tail            <= tail + 1'b1;
            end else if (!alloc.alloc_req) begin
                alloc.alloc_ack <= 1'b0; // four-phase return to zero
            end
            if (retire.retire_pop) begin
                head <= head + 1'b1;
            end
            case ({alloc_fire, retire.retire_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

    // entry payload and granted tag
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            alloc.alloc_tag      <= tail;
            entries[tail].dest   <= alloc.alloc_dest;
            entries[tail].writes <= alloc.alloc_writes;
            entries[tail].done   <= 1'b0;
        end
        if (cpl_in_flight) begin
            entries[complete_tag].done <= 1'b1; // never the tail slot, that one is free
        end
    end

    assign retire.head_valid  = (count != '0) && entries[head].done;
    assign retire.head_tag    = head;
    assign retire.head_dest   = entries[head].dest;
    assign retire.head_writes = entries[head].writes;

endmodule

// File: logic/rob_if.sv
// handshake bundles between the issue unit, the rob and the commit unit
// rob_alloc_if is four-phase req/ack, rob_retire_if exposes the rob head
`timescale 1ns/10ps
`include "rename_cfg.svh"

interface rob_alloc_if;
    logic              alloc_req;    // held high with dest/writes until ack
    logic [4:0]        alloc_dest;
    logic              alloc_writes;
    logic              alloc_ack;    // only raised with a free slot
    logic [`TAG_W-1:0] alloc_tag;    // valid while ack is high

    modport issue (
        output alloc_req, alloc_dest, alloc_writes,
        input  alloc_ack, alloc_tag
    );
    modport rob (
        input  alloc_req, alloc_dest, alloc_writes,
        output alloc_ack, alloc_tag
    );
endinterface

interface rob_retire_if;
    logic              head_valid;  // head entry is done
    logic [`TAG_W-1:0] head_tag;
    logic [4:0]        head_dest;
    logic              head_writes;
    logic              retire_pop;  // one cycle pulse, frees the head

    modport rob (
        output head_valid, head_tag, head_dest, head_writes,
        input  retire_pop
    );
    modport commit (
        input  head_valid, head_tag, head_dest, head_writes,
        output retire_pop
    );
endinterface

// File: src.f
+incdir+include
logic/rename_pkg.sv
logic/rob_if.sv
logic/regstat.sv
logic/issue_unit.sv
logic/reorder_buffer.sv
logic/commit_unit.sv
logic/rename_core.sv
testbench/clock_gen.sv
testbench/rename_props.sv
testbench/rename_tb.sv

// File: testbench/clock_gen.sv
// clock and power-on reset for the testbench
// reset is held for a fixed number of cycles and released just after an edge
`timescale 1ns/10ps

module clock_gen #(
    parameter int PERIOD       = 4, // ns
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #0.5 reset = 1'b0; // same offset as the rest of the stimulus
    end

endmodule

// File: testbench/rename_props.sv
// concurrent checks on the instruction and commit handshakes and the rob fill level
// bound into rename_core from the testbench, fail_count is read back there
`timescale 1ns/10ps
`include "rename_cfg.svh"

module rename_props (
    input logic              clk,
    input logic              reset,
    input logic              instr_req,
    input logic              instr_ack,
    input logic              commit_req,
    input logic              commit_ack,
    input logic [`TAG_W-1:0] commit_tag,
    input logic [4:0]        commit_dest,
    input logic              commit_writes,
    input logic [`TAG_W:0]   rob_count
);

    int fail_count = 0;

    // ack only rises on a request seen high at the previous edge
    ack_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(instr_ack) |-> $past(instr_req))
        else begin $error("instr_ack rose without instr_req"); fail_count++; end

    ack_hold: assert property (@(posedge clk) disable iff (reset)
        instr_ack && instr_req |=> instr_ack)
        else begin $error("instr_ack dropped while instr_req high"); fail_count++; end

    ack_fall: assert property (@(posedge clk) disable iff (reset)
        $fell(instr_ack) |-> !$past(instr_req))
        else begin $error("instr_ack fell before instr_req fell"); fail_count++; end

    // commit payload frozen until the outside answers
    creq_hold: assert property (@(posedge clk) disable iff (reset)
        commit_req && !commit_ack |=> commit_req && $stable(commit_tag)
            && $stable(commit_dest) && $stable(commit_writes))
        else begin $error("commit_req or payload changed before ack"); fail_count++; end

    creq_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(commit_req) |-> !$past(commit_ack))
        else begin $error("commit_req rose while commit_ack high"); fail_count++; end

    creq_fall: assert property (@(posedge clk) disable iff (reset)
        $fell(commit_req) |-> $past(commit_ack))
        else begin $error("commit_req fell without commit_ack"); fail_count++; end

    rob_fill: assert property (@(posedge clk) disable iff (reset)
        rob_count <= `ROB_DEPTH)
        else begin $error("rob count above depth"); fail_count++; end

endmodule

// File: testbench/rename_tb.sv
// testbench for the rename and retire slice
// drives both four-phase handshakes and completions, a reference model of the
// status table and the in-order queue predicts every issue and commit
`timescale 1ns/10ps
`include "rename_cfg.svh"

module rename_tb import rename_pkg::*; ();

    localparam int CLK_NS           = 4;
    localparam int TOTAL_INSTR      = 8 + `ROB_DEPTH + 1 + 200; // directed, full rob, random
    localparam int CYCLES_PER_INSTR = 200;

    typedef struct packed {
        logic [`TAG_W-1:0] tag;
        logic [4:0]        dest;
        logic              writes;
    } flight_t;

    typedef struct packed {
        logic [`TAG_W-1:0] q_j;
        logic [`TAG_W-1:0] q_k;
        logic              rs1_busy;
        logic              rs2_busy;
        logic [11:0]       imm;
        logic              uses_rs2;
        logic              writes;
        logic [4:0]        dest;
    } issue_exp_t;

    logic              clk;
    logic              reset;
    logic              instr_req;
    logic [31:0]       instr_word;
    logic              instr_ack;
    logic [`TAG_W-1:0] q_j;
    logic [`TAG_W-1:0] q_k;
    logic              rs1_busy;
    logic              rs2_busy;
    logic [`TAG_W-1:0] rob_tag;
    logic [11:0]       imm;
    logic              uses_rs2;
    logic              complete_valid;
    logic [`TAG_W-1:0] complete_tag;
    logic              commit_req;
    logic              commit_ack;
    logic [`TAG_W-1:0] commit_tag;
    logic [4:0]        commit_dest;
    logic              commit_writes;

    // reference model state
    logic              model_busy [`NUM_REGS];
    logic [`TAG_W-1:0] model_tag  [`NUM_REGS];
    logic [`TAG_W-1:0] next_tag;
    flight_t           in_flight [$];  // program order, oldest first
    logic [`TAG_W-1:0] not_done [$];   // issued, completion not yet sent
    logic [`TAG_W-1:0] force_done [$]; // completions asked for by directed steps
    int                commit_count;
    logic              auto_complete;
    logic [31:0]       lfsr;
    logic [31:0]       cpl_rand;
    logic [31:0]       ack_rand;
    int                cpl_idx;
    logic              prev_ack  = 1'b0;
    logic              prev_creq = 1'b0;

    clock_gen #(.PERIOD(CLK_NS), .RESET_CYCLES(4)) u_clk (.clk, .reset);

    rename_core UUT (.*);

    bind rename_core rename_props u_props (
        .clk, .reset, .instr_req, .instr_ack, .commit_req, .commit_ack,
        .commit_tag, .commit_dest, .commit_writes,
        .rob_count(u_rob.count)
    );

    // 32-bit fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr); // one step per bit taken
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            abort_run();
        end
    endtask

    function automatic logic [31:0] make_op(input logic [4:0] rd, rs1, rs2);
        return {7'd0, rs2, rs1, 3'b000, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] make_op_imm(input logic [4:0] rd, rs1, input logic [11:0] i);
        return {i, rs1, 3'b000, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] make_load(input logic [4:0] rd, rs1, input logic [11:0] i);
        return {i, rs1, 3'b010, rd, 7'b0000011}; // LOAD, not accepted
    endfunction

    // expected rename result straight from the riscv field layout
    function automatic issue_exp_t expect_issue(input logic [31:0] word);
        issue_exp_t e;
        logic [6:0] opc;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        opc = word[6:0];
        rd  = word[11:7];
        rs1 = word[19:15];
        rs2 = word[24:20];
        e   = '0;
        if (opc == OPC_OP || opc == OPC_OP_IMM) begin
            e.q_j      = model_tag[rs1];
            e.rs1_busy = model_busy[rs1];
            e.writes   = (rd != 5'd0); // x0 is never claimed
            e.dest     = e.writes ? rd : 5'd0;
        end
        if (opc == OPC_OP) begin
            e.q_k      = model_tag[rs2];
            e.rs2_busy = model_busy[rs2];
            e.uses_rs2 = 1'b1;
        end else if (opc == OPC_OP_IMM) begin
            e.imm = word[31:20];
        end
        return e;
    endfunction

    task automatic model_commit();
        flight_t f;
        if (in_flight.size() == 0) begin
            $display("commit_req rose with no instruction in flight");
            abort_run();
        end
        f = in_flight.pop_front();
        foreach (not_done[i]) begin
            if (not_done[i] == f.tag) begin
                $display("tag %0h committed before it was completed", f.tag);
                abort_run();
            end
        end
        check("commit_tag", commit_tag, f.tag);
        check("commit_dest", commit_dest, f.dest);
        check("commit_writes", commit_writes, f.writes);
        if (f.writes && model_busy[f.dest] && (model_tag[f.dest] == f.tag)) begin
            model_busy[f.dest] = 1'b0; // only the newest writer frees it
            model_tag[f.dest]  = '0;
        end
        commit_count++;
    endtask

    task automatic model_issue();
        issue_exp_t e;
        flight_t    f;
        e = expect_issue(instr_word); // sources before own dest write
        check("rob_tag", rob_tag, next_tag);
        check("q_j", q_j, e.q_j);
        check("q_k", q_k, e.q_k);
        check("rs1_busy", rs1_busy, e.rs1_busy);
        check("rs2_busy", rs2_busy, e.rs2_busy);
        check("imm", imm, e.imm);
        check("uses_rs2", uses_rs2, e.uses_rs2);
        if (e.writes) begin
            model_busy[e.dest] = 1'b1;
            model_tag[e.dest]  = next_tag;
        end
        f.tag    = next_tag;
        f.dest   = e.dest;
        f.writes = e.writes;
        in_flight.push_back(f);
        not_done.push_back(next_tag);
        if (in_flight.size() > `ROB_DEPTH) begin
            $display("instr_ack rose with the reorder buffer already full");
            abort_run();
        end
        next_tag = next_tag + 1'b1; // wraps mod depth
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #0.5;
    endtask

    task automatic start_issue(input logic [31:0] word);
        next_cycle();
        instr_word = word;
        instr_req  = 1'b1;
    endtask

    task automatic finish_issue();
        do next_cycle(); while (instr_ack !== 1'b1);
        instr_req = 1'b0;
        do next_cycle(); while (instr_ack !== 1'b0);
    endtask

    task automatic issue_one(input logic [31:0] word);
        start_issue(word);
        finish_issue();
    endtask

    task automatic random_issue();
        logic [31:0] cls;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] i;
        draw_bits(3, cls);
        draw_bits(3, rd); // x0..x7 keeps hazards frequent
        draw_bits(3, rs1);
        draw_bits(3, rs2);
        draw_bits(12, i);
        if (cls < 4) begin
            issue_one(make_op(rd[4:0], rs1[4:0], rs2[4:0]));
        end else if (cls < 7) begin
            issue_one(make_op_imm(rd[4:0], rs1[4:0], i[11:0]));
        end else begin
            issue_one(make_load(rd[4:0], rs1[4:0], i[11:0]));
        end
    endtask

    task automatic request_completion(input logic [`TAG_W-1:0] tag);
        for (int i = 0; i < not_done.size(); i++) begin
            if (not_done[i] == tag) begin
                not_done.delete(i);
                break;
            end
        end
        force_done.push_back(tag);
    endtask

    task automatic wait_commits(input int n);
        while (commit_count < n) next_cycle();
    endtask

    task automatic wait_drain();
        while (in_flight.size() != 0 || commit_req !== 1'b0 || commit_ack !== 1'b0) begin
            next_cycle();
        end
    endtask

    // compare process, samples settled outputs after each edge
    always begin
        @(posedge clk);
        #1;
        if (!reset) begin
            if (UUT.u_props.fail_count != 0) begin
                $display("a handshake or rob count assertion failed");
                abort_run();
            end
            if (commit_req && !prev_creq) model_commit(); // clear lands before a same-edge issue
            if (instr_ack && !prev_ack) model_issue();
        end
        prev_ack  = instr_ack;
        prev_creq = commit_req;
    end

    // completion pulses, directed ones first, else random in-flight tags
    always begin
        next_cycle();
        complete_valid = 1'b0;
        if (force_done.size() != 0) begin
            complete_valid = 1'b1;
            complete_tag   = force_done.pop_front();
        end else if (auto_complete && not_done.size() != 0) begin
            draw_bits(2, cpl_rand);
            if (cpl_rand != 0) begin
                draw_bits(4, cpl_rand);
                cpl_idx        = cpl_rand % not_done.size();
                complete_valid = 1'b1;
                complete_tag   = not_done[cpl_idx];
                not_done.delete(cpl_idx);
            end
        end
    end

    // outside end of the commit handshake with random delays
    always begin
        next_cycle();
        if (commit_req === 1'b1 && commit_ack === 1'b0) begin
            draw_bits(2, ack_rand);
            repeat (ack_rand) next_cycle();
            commit_ack = 1'b1;
            while (commit_req === 1'b1) next_cycle();
            draw_bits(2, ack_rand);
            repeat (ack_rand) next_cycle();
            commit_ack = 1'b0;
        end
    end

    initial begin
        #(TOTAL_INSTR * CYCLES_PER_INSTR * CLK_NS);
        $display("watchdog expired, the DUT stopped answering");
        abort_run();
    end

    initial begin
        instr_req      = 1'b0;
        instr_word     = '0;
        complete_valid = 1'b0;
        complete_tag   = '0;
        commit_ack     = 1'b0;
        lfsr           = 32'h4b2c;
        next_tag       = '0;
        commit_count   = 0;
        auto_complete  = 1'b0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_busy[i] = 1'b0;
            model_tag[i]  = '0;
        end
        @(negedge reset);
        next_cycle();
        check("instr_ack after reset", instr_ack, 1'b0);
        check("commit_req after reset", commit_req, 1'b0);

        issue_one(make_op(5'd5, 5'd1, 5'd2));          // tag 0 claims x5
        issue_one(make_op(5'd5, 5'd5, 5'd5));          // reads x5 before claiming it
        issue_one(make_op_imm(5'd6, 5'd5, 12'habc));
        issue_one(make_op_imm(5'd0, 5'd5, 12'h123));   // x0 dest writes nothing
        issue_one(make_load(5'd7, 5'd3, 12'h010));     // rejected opcode
        issue_one(make_op(5'd8, 5'd0, 5'd7));
        request_completion(4'd0);                      // older x5 writer retires
        wait_commits(1);
        issue_one(make_op(5'd9, 5'd5, 5'd6));          // x5 still held by tag 1
        request_completion(4'd1);
        wait_commits(2);
        issue_one(make_op(5'd10, 5'd5, 5'd6));         // x5 free now
        auto_complete = 1'b1;
        wait_drain();

        // fill the rob with nothing completed, next issue must stall
        auto_complete = 1'b0;
        repeat (`ROB_DEPTH) random_issue();
        start_issue(make_op(5'd11, 5'd5, 5'd6));
        repeat (20) begin
            next_cycle();
            check("instr_ack while rob full", instr_ack, 1'b0);
        end
        request_completion(in_flight[0].tag);
        finish_issue();

        auto_complete = 1'b1;
        repeat (200) random_issue();
        wait_drain();

        if (UUT.u_props.fail_count != 0) begin
            $display("a handshake or rob count assertion failed");
            abort_run();
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule
